//--- hdl/mst_driver_pkg.sv
// AXI4-lite traffic master
// Shared types and response prediction

`default_nettype none

package mst_driver_pkg;

    localparam int ADDR_W = 8;
    localparam int ID_W   = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // AW and W payload, always issued together
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } rd_req_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } b_rsp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        axi_resp_e         resp;
        logic [DATA_W-1:0] data;
    } r_rsp_t;

    // Response code the slave must return for an address
    function automatic axi_resp_e expected_resp(input logic [ADDR_W-1:0] addr);
        return axi_resp_e'(addr[3:2]);
    endfunction

    // Read data the slave must return for an address
    function automatic logic [DATA_W-1:0] expected_rdata(input logic [ADDR_W-1:0] addr);
        return {{(DATA_W - ADDR_W){1'b0}}, addr};
    endfunction

endpackage

`default_nettype wire

//--- hdl/lfsr32.sv
// 32-bit Galois LFSR

`timescale 1ns/1ps
`default_nettype none

module lfsr32 #(
    parameter logic [31:0] KEY = 32'hFFFF_FFFF
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        en,
    output logic [31:0] lfsr
);

    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    localparam logic [31:0] POLY = 32'h8020_0003;
    // All-zero state would lock up
    localparam logic [31:0] SEED = (KEY != 32'h0) ? KEY : 32'h1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= SEED;
        end else if (en) begin
            lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? POLY : 32'h0);
        end
    end

endmodule

`default_nettype wire

//--- hdl/req_issuer.sv
// Random request issuer for one channel

`timescale 1ns/1ps
`default_nettype none

module req_issuer #(
    parameter logic [mst_driver_pkg::ID_W-1:0] MST_ID = 8'h10,
    parameter int                              OSTD_NUM = 4,
    parameter logic [31:0]                     KEY = 32'hFFFF_FFFF,
    localparam int                             SLOT_W = (OSTD_NUM > 1) ? $clog2(OSTD_NUM) : 1
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                en,
    input  logic [mst_driver_pkg::ADDR_W-1:0]   addr_min,
    input  logic [mst_driver_pkg::ADDR_W-1:0]   addr_max,
    input  logic                                ready,
    input  logic                                slot_busy,
    output logic                                valid,
    output logic [SLOT_W-1:0]                   slot,
    output logic [mst_driver_pkg::ADDR_W-1:0]   addr,
    output logic [mst_driver_pkg::DATA_W-1:0]   data,
    output logic [mst_driver_pkg::STRB_W-1:0]   strb
);

    import mst_driver_pkg::*;

    logic [31:0]       lfsr;
    logic [31:0]       pace;
    logic              accept;
    logic [ADDR_W-1:0] raw_addr;

    assign accept = valid & ready;

    // Seed differs per master so several instances do not run in lockstep
    lfsr32 #(
        .KEY (KEY ^ 32'(MST_ID))
    ) u_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (accept),
        .lfsr    (lfsr)
    );

    //////////////////////////////
    // Valid pacing
    //////////////////////////////

    // Shifts right while idle, so bit 0 gives random gaps
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pace <= 32'h0;
        end else if (pace == 32'h0 || accept) begin
            pace <= lfsr;
        end else if (!valid) begin
            pace <= pace >> 1;
        end
    end

    assign valid = pace[0] & en & ~slot_busy;

    // Slot index, wraps at OSTD_NUM
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            slot <= '0;
        end else if (accept) begin
            slot <= (slot == SLOT_W'(OSTD_NUM - 1)) ? '0 : slot + 1'b1;
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    assign raw_addr = lfsr[ADDR_W-1:0];

    // Clamp into the target window, always word aligned
    always_comb begin
        if (raw_addr > addr_max) begin
            addr = {addr_max[ADDR_W-1:2], 2'b00};
        end else if (raw_addr < addr_min) begin
            addr = {addr_min[ADDR_W-1:2], 2'b00};
        end else begin
            addr = {raw_addr[ADDR_W-1:2], 2'b00};
        end
    end

    assign data = lfsr[DATA_W-1:0];
    assign strb = lfsr[31 -: STRB_W];

endmodule

`default_nettype wire

//--- hdl/ready_pacer.sv
// Random ready for a response channel

`timescale 1ns/1ps
`default_nettype none

module ready_pacer #(
    parameter logic [31:0] KEY = 32'hFFFF_FFFF
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic valid,
    output logic ready
);

    logic [31:0] lfsr;
    logic [31:0] pace;
    logic        fire;

    assign fire = valid & ready;

    lfsr32 #(
        .KEY (KEY)
    ) u_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (fire),
        .lfsr    (lfsr)
    );

    // Ready holds once high, until the handshake reloads the pattern
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pace <= 32'h0;
        end else if (pace == 32'h0 || fire) begin
            pace <= lfsr;
        end else if (!ready) begin
            pace <= pace >> 1;
        end
    end

    assign ready = pace[0];

endmodule

`default_nettype wire

//--- hdl/ostd_tracker.sv
// Outstanding request table and response checker

`timescale 1ns/1ps
`default_nettype none

module ostd_tracker #(
    parameter int  OSTD_NUM = 4,
    parameter int  TIMEOUT = 100,
    parameter bit  CHECK_DATA = 1'b0,
    localparam int SLOT_W = (OSTD_NUM > 1) ? $clog2(OSTD_NUM) : 1
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                accept,
    input  logic [SLOT_W-1:0]                   slot,
    input  logic [mst_driver_pkg::ID_W-1:0]     req_id,
    input  logic [mst_driver_pkg::ADDR_W-1:0]   req_addr,
    output logic                                slot_busy,
    input  logic                                rsp_fire,
    input  logic [mst_driver_pkg::ID_W-1:0]     rsp_id,
    input  mst_driver_pkg::axi_resp_e           rsp_resp,
    input  logic [mst_driver_pkg::DATA_W-1:0]   rsp_data,
    output logic                                error
);

    import mst_driver_pkg::*;

    // Counter saturates one above TIMEOUT so each request times out once
    localparam int TMR_W = $clog2(TIMEOUT + 2);

    logic [OSTD_NUM-1:0] busy;
    logic [ID_W-1:0]     slot_id  [OSTD_NUM];
    axi_resp_e           exp_resp [OSTD_NUM];
    logic [DATA_W-1:0]   exp_data [OSTD_NUM];
    logic [TMR_W-1:0]    tmr      [OSTD_NUM];
    logic [OSTD_NUM-1:0] rsp_hit;
    logic [OSTD_NUM-1:0] mismatch;
    logic [OSTD_NUM-1:0] expired;

    assign slot_busy = busy[slot];

    // Expectations captured at acceptance
    always_ff @(posedge aclk) begin
        if (accept) begin
            slot_id[slot]  <= req_id;
            exp_resp[slot] <= expected_resp(req_addr);
            // Only compared on the read path
            exp_data[slot] <= expected_rdata(req_addr);
        end
    end

    //////////////////////////////
    // Response match
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < OSTD_NUM; i++) begin
            rsp_hit[i]  = rsp_fire && busy[i] && (slot_id[i] == rsp_id);
            mismatch[i] = rsp_hit[i] &&
                          ((exp_resp[i] != rsp_resp) ||
                           (CHECK_DATA && (exp_data[i] != rsp_data)));
            expired[i]  = busy[i] && (tmr[i] == TMR_W'(TIMEOUT));
        end
    end

    //////////////////////////////
    // Slot state and timers
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy  <= '0;
            error <= 1'b0;
            for (int i = 0; i < OSTD_NUM; i++) begin
                tmr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < OSTD_NUM; i++) begin
                if (accept && slot == SLOT_W'(i)) begin
                    busy[i] <= 1'b1;
                end else if (rsp_hit[i]) begin
                    busy[i] <= 1'b0;
                end
                if (!busy[i]) begin
                    tmr[i] <= '0;
                end else if (tmr[i] != TMR_W'(TIMEOUT + 1)) begin
                    tmr[i] <= tmr[i] + 1'b1;
                end
            end
            error <= (|mismatch) || (|expired);
        end
    end

endmodule

`default_nettype wire

//--- hdl/mst_driver.sv
// AXI4-lite traffic master top level

`timescale 1ns/1ps
`default_nettype none

module mst_driver #(
    parameter logic [mst_driver_pkg::ID_W-1:0] MST_ID = 8'h10,
    parameter int                              OSTD_NUM = 4,
    parameter int                              TIMEOUT = 100,
    parameter logic [31:0]                     KEY = 32'hFFFF_FFFF
) (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              en,
    input  logic [mst_driver_pkg::ADDR_W-1:0] addr_min,
    input  logic [mst_driver_pkg::ADDR_W-1:0] addr_max,
    output logic                              error,
    output logic                              awvalid,
    output logic                              wvalid,
    input  logic                              awready,
    input  logic                              wready,
    output mst_driver_pkg::wr_req_t           aw_req,
    input  logic                              bvalid,
    output logic                              bready,
    input  mst_driver_pkg::b_rsp_t            b_rsp,
    output logic                              arvalid,
    input  logic                              arready,
    output mst_driver_pkg::rd_req_t           ar_req,
    input  logic                              rvalid,
    output logic                              rready,
    input  logic                              rlast,
    input  mst_driver_pkg::r_rsp_t            r_rsp
);

    import mst_driver_pkg::*;

    localparam int SLOT_W = (OSTD_NUM > 1) ? $clog2(OSTD_NUM) : 1;

    logic              wr_accept;
    logic              wr_busy;
    logic [SLOT_W-1:0] wr_slot;
    logic              wr_error;
    logic              rd_accept;
    logic              rd_busy;
    logic [SLOT_W-1:0] rd_slot;
    logic              rd_error;

    //////////////////////////////
    // Write path
    //////////////////////////////

    assign wvalid    = awvalid;
    assign wr_accept = awvalid & awready & wready;
    assign aw_req.id = MST_ID + ID_W'(wr_slot);

    req_issuer #(.MST_ID(MST_ID), .OSTD_NUM(OSTD_NUM), .KEY(KEY)) u_wr_issuer (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .addr_min (addr_min), .addr_max (addr_max),
        .ready (awready & wready), .slot_busy (wr_busy),
        .valid (awvalid), .slot (wr_slot),
        .addr (aw_req.addr), .data (aw_req.data), .strb (aw_req.strb)
    );

    ready_pacer #(.KEY(KEY ^ 32'hA5A5_0F0F)) u_b_pacer (
        .aclk (aclk), .aresetn (aresetn), .valid (bvalid), .ready (bready)
    );

    ostd_tracker #(.OSTD_NUM(OSTD_NUM), .TIMEOUT(TIMEOUT), .CHECK_DATA(1'b0)) u_wr_tracker (
        .aclk (aclk), .aresetn (aresetn),
        .accept (wr_accept), .slot (wr_slot),
        .req_id (aw_req.id), .req_addr (aw_req.addr), .slot_busy (wr_busy),
        .rsp_fire (bvalid & bready), .rsp_id (b_rsp.id), .rsp_resp (b_rsp.resp),
        .rsp_data ('0), .error (wr_error)
    );

    //////////////////////////////
    // Read path
    //////////////////////////////

    assign rd_accept = arvalid & arready;
    assign ar_req.id = MST_ID + ID_W'(rd_slot);

    req_issuer #(.MST_ID(MST_ID), .OSTD_NUM(OSTD_NUM), .KEY(KEY ^ 32'h5A5A_5A5A)) u_rd_issuer (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .addr_min (addr_min), .addr_max (addr_max),
        .ready (arready), .slot_busy (rd_busy),
        .valid (arvalid), .slot (rd_slot),
        .addr (ar_req.addr), .data (), .strb ()
    );

    ready_pacer #(.KEY(KEY ^ 32'h0F0F_A5A5)) u_r_pacer (
        .aclk (aclk), .aresetn (aresetn), .valid (rvalid), .ready (rready)
    );

    // Only the last beat closes a read
    ostd_tracker #(.OSTD_NUM(OSTD_NUM), .TIMEOUT(TIMEOUT), .CHECK_DATA(1'b1)) u_rd_tracker (
        .aclk (aclk), .aresetn (aresetn),
        .accept (rd_accept), .slot (rd_slot),
        .req_id (ar_req.id), .req_addr (ar_req.addr), .slot_busy (rd_busy),
        .rsp_fire (rvalid & rready & rlast), .rsp_id (r_rsp.id), .rsp_resp (r_rsp.resp),
        .rsp_data (r_rsp.data), .error (rd_error)
    );

    assign error = wr_error | rd_error;

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock source

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter time PERIOD = 100
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
        forever begin
            #(PERIOD / 2) aclk = ~aclk;
        end
    end

endmodule

`default_nettype wire

//--- verif/mst_driver_sva.sv
// Protocol assertions for the traffic master

`timescale 1ns/1ps
`default_nettype none

module mst_driver_sva (
    input logic                    aclk,
    input logic                    aresetn,
    input logic                    en,
    input logic                    error,
    input logic                    awvalid,
    input logic                    wvalid,
    input logic                    awready,
    input logic                    wready,
    input mst_driver_pkg::wr_req_t aw_req,
    input logic                    arvalid,
    input logic                    arready,
    input mst_driver_pkg::rd_req_t ar_req
);

    import mst_driver_pkg::*;

    // Only dropping en may withdraw a pending request
    a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (awvalid && !(awready && wready)) |=> (!en || (awvalid && $stable(aw_req))))
        else $error("awvalid dropped or aw_req changed before the handshake");

    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (arvalid && !arready) |=> (!en || (arvalid && $stable(ar_req))))
        else $error("arvalid dropped or ar_req changed before the handshake");

    a_aw_w_pair: assert property (@(posedge aclk) awvalid == wvalid)
        else $error("awvalid and wvalid differ");

    a_reset_error: assert property (@(posedge aclk) !aresetn |-> !error)
        else $error("error high during reset");

endmodule

bind mst_driver mst_driver_sva u_sva (
    .aclk    (aclk),
    .aresetn (aresetn),
    .en      (en),
    .error   (error),
    .awvalid (awvalid),
    .wvalid  (wvalid),
    .awready (awready),
    .wready  (wready),
    .aw_req  (aw_req),
    .arvalid (arvalid),
    .arready (arready),
    .ar_req  (ar_req)
);

`default_nettype wire

//--- verif/tb_mst_driver.sv
// Testbench for the AXI4-lite traffic master
// Random slave model with response checking

`timescale 1ns/1ps
`default_nettype none

module tb_mst_driver;

    import mst_driver_pkg::*;

    localparam logic [ID_W-1:0] MST_ID   = 8'h10;
    localparam int              OSTD_NUM = 4;
    localparam int              TIMEOUT  = 20;
    localparam logic [31:0]     KEY      = 32'h1357_9BDF;

    // Request held by the slave model until its response
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       acc;
    } ent_t;

    logic              aclk;
    logic              aresetn;
    logic              en;
    logic [ADDR_W-1:0] addr_min;
    logic [ADDR_W-1:0] addr_max;
    logic              error;
    logic              awvalid;
    logic              wvalid;
    logic              awready;
    logic              wready;
    wr_req_t           aw_req;
    logic              bvalid;
    logic              bready;
    b_rsp_t            b_rsp;
    logic              arvalid;
    logic              arready;
    rd_req_t           ar_req;
    logic              rvalid;
    logic              rready;
    logic              rlast;
    r_rsp_t            r_rsp;

    ent_t              wq[$];
    ent_t              rq[$];
    logic [31:0]       cyc;
    logic              exp_err;
    int unsigned       wr_n;
    int unsigned       rd_n;
    logic              b_bad;
    logic              r_bad;
    logic              inj_b;
    int                inj_r;
    int unsigned       bad_fires;
    logic [1:0]        hold_arm;
    logic [1:0]        hold_on;
    logic [ID_W-1:0]   hold_id  [2];
    logic [31:0]       hold_acc [2];
    logic [DATA_W-1:0] r_data_ok;

    tb_clock_gen #(.PERIOD(100)) u_clk (.aclk(aclk));

    mst_driver #(
        .MST_ID   (MST_ID),
        .OSTD_NUM (OSTD_NUM),
        .TIMEOUT  (TIMEOUT),
        .KEY      (KEY)
    ) i_mst_driver (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (en),
        .addr_min (addr_min),
        .addr_max (addr_max),
        .error    (error),
        .awvalid  (awvalid),
        .wvalid   (wvalid),
        .awready  (awready),
        .wready   (wready),
        .aw_req   (aw_req),
        .bvalid   (bvalid),
        .bready   (bready),
        .b_rsp    (b_rsp),
        .arvalid  (arvalid),
        .arready  (arready),
        .ar_req   (ar_req),
        .rvalid   (rvalid),
        .rready   (rready),
        .rlast    (rlast),
        .r_rsp    (r_rsp)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display(">>> FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic int find_id(input ent_t q[$], input logic [ID_W-1:0] id);
        foreach (q[i]) begin
            if (q[i].id == id) return i;
        end
        return -1;
    endfunction

    // A tracked request whose timeout error lands in this cycle
    function automatic logic any_expiring(input ent_t q[$], input logic [31:0] now);
        logic hit;
        hit = 1'b0;
        foreach (q[i]) begin
            if (q[i].acc + TIMEOUT + 1 == now) hit = 1'b1;
        end
        return hit;
    endfunction

    // Oldest entry half the time, otherwise any; the withheld ID is skipped
    function automatic int pick_rsp(input ent_t q[$], input logic held,
                                    input logic [ID_W-1:0] held_id);
        int idx;
        if (q.size() == 0 || $urandom_range(3) == 0) return -1;
        idx = $urandom_range(1) ? 0 : int'($urandom_range(q.size() - 1));
        if (held && q[idx].id == held_id) return -1;
        return idx;
    endfunction

    task automatic check_request(input string ch, input ent_t q[$], input logic [ID_W-1:0] id,
                                 input logic [ADDR_W-1:0] addr, input int unsigned n);
        logic [ADDR_W-1:0] lo;
        logic [ADDR_W-1:0] hi;
        lo = {addr_min[ADDR_W-1:2], 2'b00};
        hi = {addr_max[ADDR_W-1:2], 2'b00};
        check_value({ch, ".addr[1:0]"}, addr[1:0], 0);
        check_value({ch, ".addr in window"}, (addr >= lo) && (addr <= hi), 1);
        check_value({ch, ".id"}, id, MST_ID + n % OSTD_NUM);
        check_value({ch, ".id still outstanding"}, find_id(q, id) >= 0, 0);
    endtask

    //////////////////////////////
    // One clock cycle of the slave model
    //////////////////////////////

    task automatic step();
        logic    aw_fire;
        logic    ar_fire;
        logic    b_fire;
        logic    r_fire;
        logic    r_beat;
        wr_req_t aw_s;
        rd_req_t ar_s;
        int      idx;
        ent_t    e;

        // Sample mid-cycle, where everything has settled
        @(negedge aclk);
        check_value("error", error, exp_err);
        if (!en) begin
            check_value("awvalid", awvalid, 0);
            check_value("wvalid", wvalid, 0);
            check_value("arvalid", arvalid, 0);
        end
        aw_fire = awvalid && awready && wready;
        ar_fire = arvalid && arready;
        b_fire  = bvalid && bready;
        r_fire  = rvalid && rready && rlast;
        r_beat  = rvalid && rready && !rlast;
        aw_s    = aw_req;
        ar_s    = ar_req;

        @(posedge aclk);
        cyc = cyc + 1;
        #1;
        // Judged before this edge's responses retire their entries
        exp_err = any_expiring(wq, cyc) || any_expiring(rq, cyc);
        if (b_fire) begin
            wq.delete(find_id(wq, b_rsp.id));
            if (b_bad) begin
                exp_err = 1'b1;
                bad_fires++;
            end
            bvalid = 1'b0;
        end
        if (r_fire) begin
            rq.delete(find_id(rq, r_rsp.id));
            if (r_bad) begin
                exp_err = 1'b1;
                bad_fires++;
            end
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
        // A leading beat is ignored, the last one carries the real data
        if (r_beat) begin
            r_rsp.data = r_data_ok;
            rlast      = 1'b1;
        end
        if (aw_fire) begin
            check_request("aw_req", wq, aw_s.id, aw_s.addr, wr_n);
            e = '{id: aw_s.id, addr: aw_s.addr, acc: cyc};
            wq.push_back(e);
            wr_n++;
            if (hold_arm[0]) begin
                hold_arm[0] = 1'b0;
                hold_on[0]  = 1'b1;
                hold_id[0]  = e.id;
                hold_acc[0] = cyc;
            end
        end
        if (ar_fire) begin
            check_request("ar_req", rq, ar_s.id, ar_s.addr, rd_n);
            e = '{id: ar_s.id, addr: ar_s.addr, acc: cyc};
            rq.push_back(e);
            rd_n++;
            if (hold_arm[1]) begin
                hold_arm[1] = 1'b0;
                hold_on[1]  = 1'b1;
                hold_id[1]  = e.id;
                hold_acc[1] = cyc;
            end
        end

        if (!bvalid) begin
            idx = pick_rsp(wq, hold_on[0], hold_id[0]);
            if (idx >= 0) begin
                b_rsp.id   = wq[idx].id;
                b_rsp.resp = expected_resp(wq[idx].addr);
                if (inj_b) b_rsp.resp = axi_resp_e'(b_rsp.resp ^ 2'b01);
                b_bad  = inj_b;
                inj_b  = 1'b0;
                bvalid = 1'b1;
            end
        end
        if (!rvalid) begin
            idx = pick_rsp(rq, hold_on[1], hold_id[1]);
            if (idx >= 0) begin
                r_rsp.id   = rq[idx].id;
                r_rsp.resp = expected_resp(rq[idx].addr);
                r_rsp.data = expected_rdata(rq[idx].addr);
                if (inj_r == 1) r_rsp.resp = axi_resp_e'(r_rsp.resp ^ 2'b10);
                if (inj_r == 2) r_rsp.data = r_rsp.data ^ 32'h0001_0000;
                r_bad     = (inj_r != 0);
                inj_r     = 0;
                r_data_ok = r_rsp.data;
                rvalid    = 1'b1;
                rlast     = ($urandom_range(3) != 0);
                if (!rlast) r_rsp.data = ~r_data_ok;
            end
        end
        awready = ($urandom_range(2) != 0);
        wready  = awready;
        arready = ($urandom_range(2) != 0);
    endtask

    task automatic run(input int n);
        repeat (n) step();
    endtask

    // Bounds only move while no request is pending
    task automatic set_window(input logic [ADDR_W-1:0] lo, input logic [ADDR_W-1:0] hi);
        en = 1'b0;
        step();
        addr_min = lo;
        addr_max = hi;
        step();
        en = 1'b1;
    endtask

    // Corrupt one response; kind 0 bresp, 1 rresp, 2 rdata
    task automatic inject(input int kind);
        int unsigned start;
        int          n;
        start = bad_fires;
        if (kind == 0) inj_b = 1'b1;
        else inj_r = kind;
        n = 0;
        while (bad_fires == start) begin
            if (n == 300) timeout_fail("corrupted response was never accepted");
            step();
            n++;
        end
        // Pulse high, then low again
        run(2);
    endtask

    // Path 0 write, 1 read
    task automatic withhold_one(input int path);
        int n;
        hold_arm[path] = 1'b1;
        n = 0;
        while (!(hold_on[path] && cyc > hold_acc[path] + TIMEOUT + 2)) begin
            if (n == 400) timeout_fail("withheld request was never accepted or timed out");
            step();
            n++;
        end
        hold_on[path] = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (wq.size() != 0 || rq.size() != 0) begin
            if (n == 500) timeout_fail("responses did not drain with en low");
            step();
            n++;
        end
    endtask

    initial begin
        void'($urandom(32'h6ab));
        aresetn  = 1'b0;
        en       = 1'b0;
        addr_min = 8'h00;
        addr_max = 8'hFF;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        b_rsp    = '0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rlast    = 1'b0;
        r_rsp    = '0;
        cyc      = '0;
        exp_err  = 1'b0;
        wr_n     = 0;
        rd_n     = 0;
        b_bad    = 1'b0;
        r_bad    = 1'b0;
        inj_b    = 1'b0;
        inj_r    = 0;
        bad_fires = 0;
        hold_arm = '0;
        hold_on  = '0;
        r_data_ok = '0;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        set_window(8'h00, 8'hFF);
        run(2000);
        set_window(8'h40, 8'h7F);
        run(300);
        set_window(8'h13, 8'h2E);
        run(300);
        set_window(8'hA2, 8'hA2);
        run(200);

        set_window(8'h00, 8'hFF);
        inject(0);
        inject(1);
        inject(2);
        withhold_one(0);
        withhold_one(1);
        run(100);

        en = 1'b0;
        run(60);
        drain();
        en = 1'b1;
        run(200);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/mst_driver_pkg.sv
hdl/lfsr32.sv
hdl/req_issuer.sv
hdl/ready_pacer.sv
hdl/ostd_tracker.sv
hdl/mst_driver.sv
verif/tb_clock_gen.sv
verif/mst_driver_sva.sv
verif/tb_mst_driver.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_mst_driver \
    -o tb_mst_driver_sim &&
./obj_dir/tb_mst_driver_sim | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
